// ==== verilog/merge_pkg.sv ====
package merge_pkg;

   // Width of one run word, zero is reserved as the run terminator
   localparam int DATA_W = 32;

   // Number of independent merge lanes and the width of a lane index
   localparam int LANES = 4;
   localparam int LANE_W = 2;

   // Entries per run FIFO, kept a power of two so the pointers wrap by themselves
   localparam int FIFO_DEPTH = 8;
   localparam int PTR_W = $clog2(FIFO_DEPTH);

   // The count needs one extra bit to tell full from empty
   localparam int CNT_W = PTR_W + 1;

   // Lane controller states
   // NOMINAL compares both heads, DONE_A and DONE_B drain the run that is still open
   // TOGGLE consumes both terminators and closes the merged run
   typedef enum logic [1:0] {
      NOMINAL = 2'd0,
      TOGGLE  = 2'd1,
      DONE_A  = 2'd2,
      DONE_B  = 2'd3
   } merge_state_e;

endpackage

// ==== verilog/merge_if.sv ====
`timescale 1ns/100ps

// Write side of one lane, from the loader into the two run FIFOs
interface lane_load_if;
   logic                        push_a;
   logic                        push_b;
   logic [merge_pkg::DATA_W-1:0] data;
   logic                        full_a;
   logic                        full_b;

   // The loader steers words in and watches the full levels
   modport loader (output push_a, output push_b, output data,
                   input full_a, input full_b);

   // The lane accepts words and reports how full each side is
   modport lane (input push_a, input push_b, input data,
                 output full_a, output full_b);
endinterface

// Read side of one lane, from its output register into the collector
interface lane_out_if;
   logic                        valid;
   logic [merge_pkg::DATA_W-1:0] data;
   logic                        last;
   logic                        take;

   // valid is a level, take is a one-cycle pulse that frees the register
   modport lane (output valid, output data, output last, input take);

   modport collector (input valid, input data, input last, output take);
endinterface

// ==== verilog/run_fifo.sv ====
`timescale 1ns/100ps

module run_fifo (
   input  logic                         i_clk,
   input  logic                         i_reset,
   input  logic                         i_push,
   input  logic [merge_pkg::DATA_W-1:0] i_data,
   input  logic                         i_pop,
   output logic [merge_pkg::DATA_W-1:0] o_head,
   output logic                         o_empty,
   output logic                         o_full,
   output logic                         o_head_zero
);
   logic [merge_pkg::DATA_W-1:0] mem [merge_pkg::FIFO_DEPTH];
   logic [merge_pkg::PTR_W-1:0]  wr_ptr;
   logic [merge_pkg::PTR_W-1:0]  rd_ptr;
   logic [merge_pkg::CNT_W-1:0]  count;
   logic                         do_push;
   logic                         do_pop;

   // A push into a full FIFO or a pop from an empty one is ignored
   assign do_push = i_push & ~o_full;
   assign do_pop  = i_pop & ~o_empty;

   always_ff @(posedge i_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leave the count unchanged
         if (do_push & ~do_pop)      count <= count + 1'b1;
         else if (do_pop & ~do_push) count <= count - 1'b1;
      end
   end

   assign o_empty = (count == '0);
   assign o_full  = (count == merge_pkg::CNT_W'(merge_pkg::FIFO_DEPTH));
   assign o_head  = mem[rd_ptr];
   // The head only counts as a terminator when something is really there
   assign o_head_zero = ~o_empty & (o_head == '0);

   a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset) !(i_pop && o_empty));
   a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset) !(i_push && o_full));
endmodule

// ==== verilog/merge_control.sv ====
`timescale 1ns/100ps

module merge_control (
   input  logic i_clk,
   input  logic i_reset,
   input  logic i_a_empty,
   input  logic i_b_empty,
   input  logic i_a_head_zero,
   input  logic i_b_head_zero,
   input  logic i_a_lte_b,
   input  logic i_out_busy,
   output logic o_pop_a,
   output logic o_pop_b,
   output logic o_load,
   output logic o_select_a,
   output logic o_emit_last
);
   merge_pkg::merge_state_e state;
   merge_pkg::merge_state_e state_next;
   logic need_a;
   logic need_b;
   logic stall;

   // DONE_A only looks at B and DONE_B only at A while the other states need both heads
   assign need_a = (state != merge_pkg::DONE_A);
   assign need_b = (state != merge_pkg::DONE_B);

   // Hold while the output word has not been taken or a needed head is missing
   assign stall = i_out_busy | (need_a & i_a_empty) | (need_b & i_b_empty);

   always_comb begin
      state_next  = state;
      o_pop_a     = 1'b0;
      o_pop_b     = 1'b0;
      o_load      = 1'b0;
      o_select_a  = 1'b1;
      o_emit_last = 1'b0;
      if (!stall) begin
         case (state)
            merge_pkg::NOMINAL: begin
               if (i_a_head_zero & i_b_head_zero) begin
                  state_next = merge_pkg::TOGGLE;
               end else if (i_a_head_zero) begin
                  state_next = merge_pkg::DONE_A;
               end else if (i_b_head_zero) begin
                  state_next = merge_pkg::DONE_B;
               end else begin
                  // The smaller head wins and A wins a tie
                  o_select_a = i_a_lte_b;
                  o_pop_a    = i_a_lte_b;
                  o_pop_b    = ~i_a_lte_b;
                  o_load     = 1'b1;
               end
            end
            merge_pkg::DONE_A: begin
               if (i_b_head_zero) begin
                  state_next = merge_pkg::TOGGLE;
               end else begin
                  o_select_a = 1'b0;
                  o_pop_b    = 1'b1;
                  o_load     = 1'b1;
               end
            end
            merge_pkg::DONE_B: begin
               if (i_a_head_zero) begin
                  state_next = merge_pkg::TOGGLE;
               end else begin
                  o_pop_a = 1'b1;
                  o_load  = 1'b1;
               end
            end
            default: begin
               // Both terminators leave together and one zero closes the run
               o_pop_a     = 1'b1;
               o_pop_b     = 1'b1;
               o_load      = 1'b1;
               o_emit_last = 1'b1;
               state_next  = merge_pkg::NOMINAL;
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) state <= merge_pkg::NOMINAL;
      else         state <= state_next;
   end

   // A double pop only happens in TOGGLE and only ever removes the two terminators
   a_dual_pop: assert property (@(posedge i_clk) disable iff (i_reset)
      (o_pop_a && o_pop_b) |->
         (state == merge_pkg::TOGGLE && i_a_head_zero && i_b_head_zero));
endmodule

// ==== verilog/merge_lane.sv ====
`timescale 1ns/100ps

module merge_lane (
   input  logic      i_clk,
   input  logic      i_reset,
   lane_load_if.lane load,
   lane_out_if.lane  out
);
   logic [merge_pkg::DATA_W-1:0] head_a;
   logic [merge_pkg::DATA_W-1:0] head_b;
   logic                         a_empty;
   logic                         b_empty;
   logic                         a_head_zero;
   logic                         b_head_zero;
   logic                         pop_a;
   logic                         pop_b;
   logic                         out_load;
   logic                         select_a;
   logic                         emit_last;
   logic                         out_valid;
   logic [merge_pkg::DATA_W-1:0] out_data;
   logic                         out_last;

   run_fifo fifo_a_i (.i_clk(i_clk), .i_reset(i_reset), .i_push(load.push_a), .i_data(load.data),
                      .i_pop(pop_a), .o_head(head_a), .o_empty(a_empty), .o_full(load.full_a),
                      .o_head_zero(a_head_zero));
   run_fifo fifo_b_i (.i_clk(i_clk), .i_reset(i_reset), .i_push(load.push_b), .i_data(load.data),
                      .i_pop(pop_b), .o_head(head_b), .o_empty(b_empty), .o_full(load.full_b),
                      .o_head_zero(b_head_zero));

   // A take in this cycle frees the register so the next word can load on the same edge
   merge_control control_i (.i_clk(i_clk), .i_reset(i_reset), .i_a_empty(a_empty),
                            .i_b_empty(b_empty), .i_a_head_zero(a_head_zero),
                            .i_b_head_zero(b_head_zero), .i_a_lte_b(head_a <= head_b),
                            .i_out_busy(out_valid & ~out.take), .o_pop_a(pop_a), .o_pop_b(pop_b),
                            .o_load(out_load), .o_select_a(select_a), .o_emit_last(emit_last));

   always_ff @(posedge i_clk) begin
      if (i_reset)        out_valid <= 1'b0;
      else if (out_load)  out_valid <= 1'b1;
      else if (out.take)  out_valid <= 1'b0;
   end

   // The closing word is always zero, whatever head was selected
   always_ff @(posedge i_clk) begin
      if (out_load) begin
         out_data <= emit_last ? '0 : (select_a ? head_a : head_b);
         out_last <= emit_last;
      end
   end

   assign out.valid = out_valid;
   assign out.data  = out_data;
   assign out.last  = out_last;
endmodule

// ==== verilog/lane_loader.sv ====
`timescale 1ns/100ps

module lane_loader (
   input  logic                         i_clk,
   input  logic                         i_reset,
   input  logic                         i_in_valid,
   input  logic [merge_pkg::LANE_W-1:0] i_in_lane,
   input  logic                         i_in_side,
   input  logic [merge_pkg::DATA_W-1:0] i_in_data,
   output logic [2*merge_pkg::LANES-1:0] o_lane_full,
   lane_load_if.loader                  load [merge_pkg::LANES]
);
   logic [merge_pkg::LANES-1:0]  push_a_q;
   logic [merge_pkg::LANES-1:0]  push_b_q;
   logic [merge_pkg::DATA_W-1:0] data_q;

   // Side 0 is run A and side 1 is run B, decoded before the register
   always_ff @(posedge i_clk) begin
      for (int l = 0; l < merge_pkg::LANES; l++) begin
         if (i_reset) begin
            push_a_q[l] <= 1'b0;
            push_b_q[l] <= 1'b0;
         end else begin
            push_a_q[l] <= i_in_valid & (i_in_lane == merge_pkg::LANE_W'(l)) & ~i_in_side;
            push_b_q[l] <= i_in_valid & (i_in_lane == merge_pkg::LANE_W'(l)) & i_in_side;
         end
      end
      data_q <= i_in_data;
   end

   for (genvar l = 0; l < merge_pkg::LANES; l++) begin : g_lane
      assign load[l].push_a = push_a_q[l];
      assign load[l].push_b = push_b_q[l];
      assign load[l].data   = data_q;
      // Even bit is side A, odd bit is side B
      assign o_lane_full[2*l]   = load[l].full_a;
      assign o_lane_full[2*l+1] = load[l].full_b;

      a_push_free: assert property (@(posedge i_clk) disable iff (i_reset)
         !(push_a_q[l] && load[l].full_a) && !(push_b_q[l] && load[l].full_b));
   end
endmodule

// ==== verilog/merge_collector.sv ====
`timescale 1ns/100ps

module merge_collector (
   input  logic                         i_clk,
   input  logic                         i_reset,
   input  logic                         i_out_full,
   lane_out_if.collector                lanes [merge_pkg::LANES],
   output logic                         o_out_valid,
   output logic [merge_pkg::LANE_W-1:0] o_out_lane,
   output logic [merge_pkg::DATA_W-1:0] o_out_data
);
   logic [merge_pkg::LANES-1:0]  lane_valid;
   logic [merge_pkg::LANES-1:0]  lane_last;
   logic [merge_pkg::DATA_W-1:0] lane_data [merge_pkg::LANES];
   logic [merge_pkg::LANE_W-1:0] grant;
   logic                         in_run;
   logic                         take;

   // Flatten the lane bundles so the granted one can be picked by index
   for (genvar l = 0; l < merge_pkg::LANES; l++) begin : g_lane
      assign lane_valid[l] = lanes[l].valid;
      assign lane_last[l]  = lanes[l].last;
      assign lane_data[l]  = lanes[l].data;
      assign lanes[l].take = take & (grant == merge_pkg::LANE_W'(l));
   end

   // No take at all while the output side pushes back
   assign take = ~i_out_full & lane_valid[grant];

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         grant  <= '0;
         in_run <= 1'b0;
      end else if (take) begin
         // The terminator releases the grant, any other word pins it
         in_run <= ~lane_last[grant];
         if (lane_last[grant]) grant <= grant + 1'b1;
      end else if (!in_run && !lane_valid[grant]) begin
         // Idle lane with no run in progress, try the next one
         grant <= grant + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) o_out_valid <= 1'b0;
      else         o_out_valid <= take;
      o_out_lane <= grant;
      o_out_data <= lane_data[grant];
   end

   a_grant_held: assert property (@(posedge i_clk) disable iff (i_reset)
      (in_run && !(take && lane_last[grant])) |=> $stable(grant));
endmodule

// ==== verilog/merge_sorter_top.sv ====
`timescale 1ns/100ps

module merge_sorter_top (
   input  logic                          i_clk,
   input  logic                          i_reset,
   input  logic                          i_in_valid,
   input  logic [merge_pkg::LANE_W-1:0]  i_in_lane,
   input  logic                          i_in_side,
   input  logic [merge_pkg::DATA_W-1:0]  i_in_data,
   input  logic                          i_out_full,
   output logic [2*merge_pkg::LANES-1:0] o_lane_full,
   output logic                          o_out_valid,
   output logic [merge_pkg::LANE_W-1:0]  o_out_lane,
   output logic [merge_pkg::DATA_W-1:0]  o_out_data
);
   // One load bundle and one output bundle per lane
   lane_load_if load_bus [merge_pkg::LANES] ();
   lane_out_if  out_bus  [merge_pkg::LANES] ();

   // Input words are steered to a lane and side one cycle after they arrive
   lane_loader loader_i (.i_clk(i_clk), .i_reset(i_reset), .i_in_valid(i_in_valid),
                         .i_in_lane(i_in_lane), .i_in_side(i_in_side), .i_in_data(i_in_data),
                         .o_lane_full(o_lane_full), .load(load_bus));

   // Every lane merges its own pair of runs independently
   for (genvar l = 0; l < merge_pkg::LANES; l++) begin : g_lane
      merge_lane lane_i (.i_clk(i_clk), .i_reset(i_reset), .load(load_bus[l]),
                         .out(out_bus[l]));
   end

   // Merged runs leave one whole run at a time, lanes visited in order
   merge_collector collector_i (.i_clk(i_clk), .i_reset(i_reset), .i_out_full(i_out_full),
                                .lanes(out_bus), .o_out_valid(o_out_valid),
                                .o_out_lane(o_out_lane), .o_out_data(o_out_data));
endmodule

// ==== verification/merge_sorter_tb.sv ====
`timescale 1ns/100ps

module merge_sorter_tb;
   localparam int TIMEOUT_CYCLES = 2000;

   logic                          i_clk;
   logic                          i_reset;
   logic                          i_in_valid;
   logic [merge_pkg::LANE_W-1:0]  i_in_lane;
   logic                          i_in_side;
   logic [merge_pkg::DATA_W-1:0]  i_in_data;
   logic                          i_out_full;
   logic [2*merge_pkg::LANES-1:0] o_lane_full;
   logic                          o_out_valid;
   logic [merge_pkg::LANE_W-1:0]  o_out_lane;
   logic [merge_pkg::DATA_W-1:0]  o_out_data;

   // Expected words per lane, every merged run closed by its own zero
   logic [merge_pkg::DATA_W-1:0] exp_q [merge_pkg::LANES][$];
   logic [merge_pkg::DATA_W-1:0] exp_word;
   logic [merge_pkg::DATA_W-1:0] mon_prev;
   logic [merge_pkg::LANE_W-1:0] mon_lane;
   logic                         mon_in_run;
   logic [15:0]                  lfsr;
   logic                         pushed_any;
   logic                         random_full_en;
   int                           pick_lane;
   int                           pick_a;
   int                           pick_b;
   int                           errors;
   int                           timeouts;
   int                           words_checked;

   merge_sorter_top dut_i (.*);

   always #10 i_clk = ~i_clk;

   // Fibonacci LFSR with taps 16 14 13 11, one step for every bit handed out
   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] r;
      logic       fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[6:0], fb};
      end
      return r;
   endfunction

   function automatic int pending_words();
      int total;
      total = 0;
      for (int l = 0; l < merge_pkg::LANES; l++) total += exp_q[l].size();
      return total;
   endfunction

   // One clock on the falling edge, with random output blocking when enabled
   task automatic tick();
      @(negedge i_clk);
      if (random_full_en) i_out_full = (rand_bits(2) == 8'd0);
   endtask

   // Waits for room on the addressed side, then holds the strobe for one cycle
   // The idle cycle after it lets o_lane_full catch up with the registered push
   task automatic push_word(input int lane, input int side, input logic [31:0] word);
      int waited;
      waited = 0;
      while (o_lane_full[2*lane+side] && waited < TIMEOUT_CYCLES) begin
         tick();
         waited++;
      end
      if (o_lane_full[2*lane+side]) begin
         timeouts++;
         $display("Timed out waiting for room in lane %0d side %0d", lane, side);
         return;
      end
      pushed_any = 1'b1;
      i_in_valid = 1'b1;
      i_in_lane  = merge_pkg::LANE_W'(lane);
      i_in_side  = (side != 0);
      i_in_data  = word;
      tick();
      i_in_valid = 1'b0;
      tick();
   endtask

   // Both runs start from one base so their words interleave and sometimes tie
   task automatic send_pair(input int lane, input int len_a, input int len_b);
      logic [31:0] run_a [$];
      logic [31:0] run_b [$];
      logic [31:0] merged [$];
      logic [31:0] base;
      logic [31:0] w;
      base = 32'(rand_bits(8)) << 20;
      w = base;
      for (int i = 0; i < len_a; i++) begin
         w = w + 32'd1 + 32'(rand_bits(4));
         run_a.push_back(w);
      end
      w = base;
      for (int i = 0; i < len_b; i++) begin
         w = w + 32'd1 + 32'(rand_bits(4));
         run_b.push_back(w);
      end
      merged = {run_a, run_b};
      merged.sort();
      foreach (merged[i]) exp_q[lane].push_back(merged[i]);
      exp_q[lane].push_back('0);
      // Side B goes first so a long A run can back up behind a stalled lane
      foreach (run_b[i]) push_word(lane, 1, run_b[i]);
      push_word(lane, 1, '0);
      foreach (run_a[i]) push_word(lane, 0, run_a[i]);
      push_word(lane, 0, '0);
   endtask

   task automatic wait_drained(input string what);
      int waited;
      waited = 0;
      while (pending_words() != 0 && waited < TIMEOUT_CYCLES) begin
         tick();
         waited++;
      end
      if (pending_words() != 0) begin
         timeouts++;
         $display("Timed out with %0d words still missing after %s", pending_words(), what);
      end
   endtask

   // Keeps the output blocked until side A of the lane reports full, then opens it
   task automatic hold_until_full(input int lane);
      int waited;
      waited = 0;
      while (!o_lane_full[2*lane] && waited < TIMEOUT_CYCLES) begin
         tick();
         waited++;
      end
      a_side_full: assert (o_lane_full[2*lane]) else begin
         errors++;
         $display("[ERROR] o_lane_full = %h, expected bit %0d set", o_lane_full, 2*lane);
      end
      repeat (6) tick();
      i_out_full = 1'b0;
   endtask

   // DUT outputs move on the rising edge only, so the falling edge sees them settled
   always @(negedge i_clk) begin
      if (o_out_valid === 1'b1) begin
         words_checked++;
         a_run_expected: assert (exp_q[o_out_lane].size() != 0) else begin
            errors++;
            $display("Lane %0d sent word %h with no merged run expected", o_out_lane, o_out_data);
         end
         if (exp_q[o_out_lane].size() != 0) begin
            exp_word = exp_q[o_out_lane].pop_front();
            a_word_match: assert (o_out_data == exp_word) else begin
               errors++;
               $display("[ERROR] o_out_data = %h, expected %h", o_out_data, exp_word);
            end
         end
         a_lane_held: assert (!mon_in_run || o_out_lane == mon_lane) else begin
            errors++;
            $display("[ERROR] o_out_lane = %h, expected %h", o_out_lane, mon_lane);
         end
         a_ascending: assert (!mon_in_run || o_out_data == '0 || o_out_data >= mon_prev) else begin
            errors++;
            $display("[ERROR] o_out_data = %h, expected at least %h", o_out_data, mon_prev);
         end
         // A zero closes the run, any other word opens or continues one
         mon_in_run = (o_out_data != '0);
         mon_lane   = o_out_lane;
         mon_prev   = o_out_data;
      end
   end

   a_idle_after_reset: assert property (@(posedge i_clk) disable iff (i_reset)
      !pushed_any |-> (!o_out_valid && o_lane_full == '0)) else begin
      errors++;
      $display("[ERROR] o_out_valid = %h, o_lane_full = %h, expected 0 and 00",
               o_out_valid, o_lane_full);
   end

   a_full_blocks: assert property (@(posedge i_clk) disable iff (i_reset)
      i_out_full |=> !o_out_valid) else begin
      errors++;
      $display("[ERROR] o_out_valid = %h, expected 0 after i_out_full high", o_out_valid);
   end

   initial begin
      i_clk          = 1'b0;
      i_reset        = 1'b1;
      i_in_valid     = 1'b0;
      i_in_lane      = '0;
      i_in_side      = 1'b0;
      i_in_data      = '0;
      i_out_full     = 1'b0;
      lfsr           = 16'd63;
      pushed_any     = 1'b0;
      random_full_en = 1'b0;
      mon_in_run     = 1'b0;
      errors         = 0;
      timeouts       = 0;
      words_checked  = 0;
      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      i_reset = 1'b0;
      repeat (3) tick();

      // Two empty runs, then one empty run on either side
      send_pair(1, 0, 0);
      send_pair(2, 0, 3);
      send_pair(3, 4, 0);
      wait_drained("the empty run cases");

      // Side A of lane 0 must fill up behind a blocked output
      i_out_full = 1'b1;
      fork
         send_pair(0, 12, 2);
         hold_until_full(0);
      join
      wait_drained("the side A fill");

      random_full_en = 1'b1;
      repeat (40) begin
         pick_lane = int'(rand_bits(2));
         pick_a    = int'(rand_bits(3)) % 6;
         pick_b    = int'(rand_bits(3)) % 6;
         send_pair(pick_lane, pick_a, pick_b);
      end
      random_full_en = 1'b0;
      i_out_full     = 1'b0;
      wait_drained("the random runs");

      $display("Checked %0d output words, %0d errors, %0d timeouts",
               words_checked, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end
endmodule

// ==== build.f ====
verilog/merge_pkg.sv
verilog/merge_if.sv
verilog/run_fifo.sv
verilog/merge_control.sv
verilog/merge_lane.sv
verilog/lane_loader.sv
verilog/merge_collector.sv
verilog/merge_sorter_top.sv
verification/merge_sorter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= merge_sorter_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
BIN        = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
